// File: common/s2mm_pkg.sv
`default_nettype none

package s2mm_pkg;

	// stream geometry
	localparam int data_w    = 32;
	localparam int keep_w    = data_w / 8;  // one keep bit per byte
	localparam int buf_depth = 512;         // beats per bank

	localparam int buf_aw = $clog2(buf_depth);
	// a full bank holds buf_depth * keep_w bytes, which needs one extra bit
	localparam int cnt_w  = $clog2(buf_depth * keep_w) + 1;

	// command fields
	localparam int addr_w = 32;
	localparam int btt_w  = 24;

	typedef logic [data_w-1:0] data_t;
	typedef logic [keep_w-1:0] keep_t;
	typedef logic [buf_aw-1:0] buf_addr_t;
	typedef logic [cnt_w-1:0]  byte_cnt_t;
	typedef logic [addr_w-1:0] dma_addr_t;
	typedef logic [btt_w-1:0]  btt_t;

	// command generator
	typedef enum logic [1:0] {
		cmd_idle,          // waiting for a start address
		cmd_wait_bank,     // waiting for the next bank report
		cmd_post,          // write command offered downstream
		cmd_wait_release   // ack high, waiting for req to drop
	} cmd_state_e;

endpackage

`default_nettype wire

// File: list.f
common/s2mm_pkg.sv
source/sp_ram.sv
wdata_stat/wdata_pingpong_buf.sv
wdata_stat/wdata_cmd_gen.sv
source/s2mm_wdata_top.sv
test/tb_s2mm_wdata.sv

// File: run_sim.sh
#!/bin/sh
# build and run the S2MM write-data testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_s2mm_wdata -Mdir obj_dir -f list.f > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_s2mm_wdata > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: source/s2mm_wdata_top.sv
`timescale 1ns/1ps
`default_nettype none

module s2mm_wdata_top (
	input  wire                        s2mm_axis_aclk,
	input  wire                        s2mm_axis_aresetn,

	input  wire s2mm_pkg::dma_addr_t   s_cmd_addr,
	input  wire                        s_cmd_fixed,
	input  wire                        s_cmd_valid,
	output logic                       s_cmd_ready,

	output s2mm_pkg::dma_addr_t        m_cmd_addr,
	output s2mm_pkg::btt_t             m_cmd_btt,
	output logic                       m_cmd_fixed,
	output logic                       m_cmd_valid,
	input  wire                        m_cmd_ready,

	input  wire s2mm_pkg::data_t       s_s2mm_data,
	input  wire s2mm_pkg::keep_t       s_s2mm_keep,
	input  wire                        s_s2mm_last,
	input  wire                        s_s2mm_valid,
	output logic                       s_s2mm_ready,

	output s2mm_pkg::data_t            m_s2mm_data,
	output s2mm_pkg::keep_t            m_s2mm_keep,
	output logic                       m_s2mm_last,
	output logic                       m_s2mm_valid,
	input  wire                        m_s2mm_ready
);
	import s2mm_pkg::*;

	// per-bank handshake between buffer and command side
	logic [1:0] bank_req;
	logic [1:0] bank_ack;
	logic [1:0] bank_last;
	byte_cnt_t  bank_bytes_0;
	byte_cnt_t  bank_bytes_1;

	wdata_pingpong_buf i_buf (
		.s2mm_axis_aclk    (s2mm_axis_aclk),
		.s2mm_axis_aresetn (s2mm_axis_aresetn),
		.s_s2mm_data       (s_s2mm_data),
		.s_s2mm_keep       (s_s2mm_keep),
		.s_s2mm_last       (s_s2mm_last),
		.s_s2mm_valid      (s_s2mm_valid),
		.s_s2mm_ready      (s_s2mm_ready),
		.m_s2mm_data       (m_s2mm_data),
		.m_s2mm_keep       (m_s2mm_keep),
		.m_s2mm_last       (m_s2mm_last),
		.m_s2mm_valid      (m_s2mm_valid),
		.m_s2mm_ready      (m_s2mm_ready),
		.bank_req          (bank_req),
		.bank_bytes_0      (bank_bytes_0),
		.bank_bytes_1      (bank_bytes_1),
		.bank_last         (bank_last),
		.bank_ack          (bank_ack)
	);

	wdata_cmd_gen i_cmd_gen (
		.s2mm_axis_aclk    (s2mm_axis_aclk),
		.s2mm_axis_aresetn (s2mm_axis_aresetn),
		.s_cmd_addr        (s_cmd_addr),
		.s_cmd_fixed       (s_cmd_fixed),
		.s_cmd_valid       (s_cmd_valid),
		.s_cmd_ready       (s_cmd_ready),
		.bank_req          (bank_req),
		.bank_bytes_0      (bank_bytes_0),
		.bank_bytes_1      (bank_bytes_1),
		.bank_last         (bank_last),
		.bank_ack          (bank_ack),
		.m_cmd_addr        (m_cmd_addr),
		.m_cmd_btt         (m_cmd_btt),
		.m_cmd_fixed       (m_cmd_fixed),
		.m_cmd_valid       (m_cmd_valid),
		.m_cmd_ready       (m_cmd_ready)
	);

endmodule

`default_nettype wire

// File: source/sp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sp_ram (
	input  wire                                             s2mm_axis_aclk,
	input  wire                                             en,
	input  wire                                             wen,
	input  wire s2mm_pkg::buf_addr_t                        addr,
	input  wire [s2mm_pkg::data_w+s2mm_pkg::keep_w-1:0]     din,
	output logic [s2mm_pkg::data_w+s2mm_pkg::keep_w-1:0]    dout
);
	import s2mm_pkg::*;

	logic [data_w+keep_w-1:0] mem [buf_depth];

	// write has priority; dout only moves on a read
	always_ff @(posedge s2mm_axis_aclk)
	begin
		if (en)
		begin
			if (wen)
				mem[addr] <= din;
			else
				dout <= mem[addr]; // registered read data
		end
	end

endmodule

`default_nettype wire

// File: test/tb_s2mm_wdata.sv
`timescale 1ns/1ps
`default_nettype none

module tb_s2mm_wdata;
	import s2mm_pkg::*;

	localparam int num_pkts = 8;
	localparam int max_len  = 1200;

	logic      s2mm_axis_aclk;
	logic      s2mm_axis_aresetn;
	dma_addr_t s_cmd_addr;
	logic      s_cmd_fixed;
	logic      s_cmd_valid;
	logic      s_cmd_ready;
	dma_addr_t m_cmd_addr;
	btt_t      m_cmd_btt;
	logic      m_cmd_fixed;
	logic      m_cmd_valid;
	logic      m_cmd_ready;
	data_t     s_s2mm_data;
	keep_t     s_s2mm_keep;
	logic      s_s2mm_last;
	logic      s_s2mm_valid;
	logic      s_s2mm_ready;
	data_t     m_s2mm_data;
	keep_t     m_s2mm_keep;
	logic      m_s2mm_last;
	logic      m_s2mm_valid;
	logic      m_s2mm_ready;

	// expected traffic in transfer order
	data_t     beat_data_q[$];
	keep_t     beat_keep_q[$];
	logic      beat_in_last_q[$];
	logic      beat_end_q[$];    // chunk end seen on m_s2mm_last
	dma_addr_t cmd_addr_q[$];
	btt_t      cmd_btt_q[$];
	logic      cmd_fixed_q[$];
	dma_addr_t pkt_addr [num_pkts];
	logic      pkt_fixed [num_pkts];
	int        cmds_before [num_pkts];

	logic [31:0] rng;
	logic stim_started;
	int out_cnt;
	int cmd_cnt;
	int cycles;
	int cycle_limit;

	s2mm_wdata_top i_dut (.*);

	always #5 s2mm_axis_aclk = ~s2mm_axis_aclk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic stop_run();
		$display("Done: errors found");
		$fatal(1, "simulation stopped on an error");
	endtask

	task automatic mismatch(input string msg);
		$display("MISMATCH at %0t ns: %s", $time, msg);
		stop_run();
	endtask

	// packets, chunk ends and the commands they should produce
	task automatic build_stimulus();
		int len;
		int chunk_beats;
		int chunk_bytes;
		dma_addr_t addr;
		keep_t keep;
		logic last;
		for (int p = 0; p < num_pkts; p++)
		begin
			rng = xorshift32(rng);
			// first two packets span three banks
			len = (p < 2) ? 1025 + int'(rng % 176) : 1 + int'(rng % max_len);
			rng = xorshift32(rng);
			pkt_addr[p]  = rng;
			pkt_fixed[p] = (p == 1) ? 1'b1 : (p == 0) ? 1'b0 : rng[31];
			cmds_before[p] = cmd_addr_q.size();
			addr = pkt_addr[p];
			chunk_beats = 0;
			chunk_bytes = 0;
			for (int i = 0; i < len; i++)
			begin
				rng  = xorshift32(rng);
				last = (i == len - 1);
				keep = last ? keep_t'((5'd2 << rng[1:0]) - 5'd1) : '1; // low mask on last
				beat_data_q.push_back(rng);
				beat_keep_q.push_back(keep);
				beat_in_last_q.push_back(last);
				chunk_beats++;
				chunk_bytes += last ? int'(rng[1:0]) + 1 : keep_w; // mask width in bytes
				beat_end_q.push_back(last || chunk_beats == buf_depth);
				if (last || chunk_beats == buf_depth)
				begin
					cmd_addr_q.push_back(addr);
					cmd_btt_q.push_back(btt_t'(chunk_bytes));
					cmd_fixed_q.push_back(pkt_fixed[p]);
					if (!pkt_fixed[p])
						addr = addr + dma_addr_t'(chunk_bytes);
					chunk_beats = 0;
					chunk_bytes = 0;
				end
			end
		end
	endtask

	task automatic drive_commands();
		for (int p = 0; p < num_pkts; p++)
		begin
			s_cmd_addr  = pkt_addr[p];
			s_cmd_fixed = pkt_fixed[p];
			s_cmd_valid = 1'b1;
			@(negedge s2mm_axis_aclk);
			while (!s_cmd_ready)
				@(negedge s2mm_axis_aclk);
			assert (cmd_cnt == cmds_before[p])
			else mismatch($sformatf("start command %0d taken after %0d of %0d commands",
				p, cmd_cnt, cmds_before[p]));
			@(posedge s2mm_axis_aclk);
			#1;
		end
		s_cmd_valid = 1'b0;
	endtask

	task automatic drive_beats();
		for (int i = 0; i < beat_data_q.size(); i++)
		begin
			s_s2mm_data  = beat_data_q[i];
			s_s2mm_keep  = beat_keep_q[i];
			s_s2mm_last  = beat_in_last_q[i];
			s_s2mm_valid = 1'b1;
			@(negedge s2mm_axis_aclk);
			while (!s_s2mm_ready)
				@(negedge s2mm_axis_aclk); // both banks busy
			@(posedge s2mm_axis_aclk);
			#1;
		end
		s_s2mm_valid = 1'b0;
	endtask

	// transfer monitor for both output streams
	always @(negedge s2mm_axis_aclk)
	begin
		if (s2mm_axis_aresetn && m_s2mm_valid && m_s2mm_ready)
		begin
			assert (out_cnt < beat_data_q.size())
			else mismatch("output beat beyond the end of the input stream");
			assert (m_s2mm_data == beat_data_q[out_cnt] && m_s2mm_keep == beat_keep_q[out_cnt])
			else mismatch($sformatf("beat %0d data %h keep %h, expected %h keep %h", out_cnt,
				m_s2mm_data, m_s2mm_keep, beat_data_q[out_cnt], beat_keep_q[out_cnt]));
			assert (m_s2mm_last == beat_end_q[out_cnt])
			else mismatch($sformatf("beat %0d last %b, expected %b", out_cnt, m_s2mm_last,
				beat_end_q[out_cnt]));
			out_cnt++;
		end
		if (s2mm_axis_aresetn && m_cmd_valid && m_cmd_ready)
		begin
			assert (cmd_cnt < cmd_addr_q.size())
			else mismatch("write command beyond the expected list");
			assert (m_cmd_addr == cmd_addr_q[cmd_cnt] && m_cmd_btt == cmd_btt_q[cmd_cnt]
				&& m_cmd_fixed == cmd_fixed_q[cmd_cnt])
			else mismatch($sformatf("cmd %0d addr %h btt %0d fixed %b, expected %h %0d %b",
				cmd_cnt, m_cmd_addr, m_cmd_btt, m_cmd_fixed, cmd_addr_q[cmd_cnt],
				cmd_btt_q[cmd_cnt], cmd_fixed_q[cmd_cnt]));
			cmd_cnt++;
		end
	end

	a_quiet_start: assert property (
		@(posedge s2mm_axis_aclk) disable iff (!s2mm_axis_aresetn)
		!stim_started |-> !m_cmd_valid && !m_s2mm_valid
	) else mismatch("output valid before any stimulus");

	a_beat_hold: assert property (
		@(posedge s2mm_axis_aclk) disable iff (!s2mm_axis_aresetn)
		m_s2mm_valid && !m_s2mm_ready |=>
			m_s2mm_valid && $stable({m_s2mm_data, m_s2mm_keep, m_s2mm_last})
	) else mismatch("m_s2mm beat dropped or changed while stalled");

	a_cmd_hold: assert property (
		@(posedge s2mm_axis_aclk) disable iff (!s2mm_axis_aresetn)
		m_cmd_valid && !m_cmd_ready |=>
			m_cmd_valid && $stable({m_cmd_addr, m_cmd_btt, m_cmd_fixed})
	) else mismatch("m_cmd dropped or changed while stalled");

	// random back-pressure on both outputs
	always @(posedge s2mm_axis_aclk)
	begin
		#1;
		rng = xorshift32(rng);
		m_s2mm_ready = rng[0] | rng[1];
		m_cmd_ready  = rng[2];
	end

	always @(posedge s2mm_axis_aclk)
	begin
		cycles = cycles + 1;
		if (cycles > cycle_limit)
		begin
			$display("timeout after %0d cycles, %0d of %0d beats and %0d of %0d commands seen",
				cycles, out_cnt, beat_data_q.size(), cmd_cnt, cmd_addr_q.size());
			stop_run();
		end
	end

	initial
	begin
		s2mm_axis_aclk    = 1'b0;
		s2mm_axis_aresetn = 1'b0;
		s_cmd_addr   = '0;
		s_cmd_fixed  = 1'b0;
		s_cmd_valid  = 1'b0;
		m_cmd_ready  = 1'b0;
		s_s2mm_data  = '0;
		s_s2mm_keep  = '0;
		s_s2mm_last  = 1'b0;
		s_s2mm_valid = 1'b0;
		m_s2mm_ready = 1'b0;
		stim_started = 1'b0;
		out_cnt = 0;
		cmd_cnt = 0;
		cycles  = 0;
		rng = 32'hf1cd5df7;
		build_stimulus();
		cycle_limit = 4 * beat_data_q.size() + 2000;

		repeat (5) @(posedge s2mm_axis_aclk);
		#1;
		s2mm_axis_aresetn = 1'b1;
		@(negedge s2mm_axis_aclk);
		assert (s_cmd_ready && s_s2mm_ready && !m_cmd_valid && !m_s2mm_valid)
		else mismatch("ready and valid levels wrong after reset");
		@(posedge s2mm_axis_aclk);
		#1;
		stim_started = 1'b1;
		fork
			drive_commands();
			drive_beats();
		join

		while (out_cnt < beat_data_q.size() || cmd_cnt < cmd_addr_q.size())
			@(negedge s2mm_axis_aclk);
		repeat (20) @(negedge s2mm_axis_aclk); // catch late extra transfers
		if (out_cnt == beat_data_q.size() && cmd_cnt == cmd_addr_q.size()
			&& !m_s2mm_valid && !m_cmd_valid)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
		begin
			$display("outputs still active after the expected traffic completed");
			stop_run();
		end
	end

endmodule

`default_nettype wire

// File: wdata_stat/wdata_cmd_gen.sv
`timescale 1ns/1ps
`default_nettype none

module wdata_cmd_gen (
	input  wire                        s2mm_axis_aclk,
	input  wire                        s2mm_axis_aresetn,

	// start-address commands
	input  wire s2mm_pkg::dma_addr_t   s_cmd_addr,
	input  wire                        s_cmd_fixed,
	input  wire                        s_cmd_valid,
	output logic                       s_cmd_ready,

	// bank reports from the buffer
	input  wire [1:0]                  bank_req,
	input  wire s2mm_pkg::byte_cnt_t   bank_bytes_0,
	input  wire s2mm_pkg::byte_cnt_t   bank_bytes_1,
	input  wire [1:0]                  bank_last,
	output logic [1:0]                 bank_ack,

	// write commands
	output s2mm_pkg::dma_addr_t        m_cmd_addr,
	output s2mm_pkg::btt_t             m_cmd_btt,
	output logic                       m_cmd_fixed,
	output logic                       m_cmd_valid,
	input  wire                        m_cmd_ready
);
	import s2mm_pkg::*;

	cmd_state_e state;
	logic bank_ptr;    // bank expected next
	logic last_chunk;  // current command ends the packet
	logic req_hit;
	logic req_gone;
	byte_cnt_t sel_bytes;

	assign sel_bytes = bank_ptr ? bank_bytes_1 : bank_bytes_0;
	assign req_hit   = (state == cmd_wait_bank) && bank_req[bank_ptr];
	assign req_gone  = (state == cmd_wait_release) && !bank_req[bank_ptr];

	assign s_cmd_ready = state == cmd_idle;
	assign m_cmd_valid = state == cmd_post;

	always_ff @(posedge s2mm_axis_aclk or negedge s2mm_axis_aresetn)
	begin
		if (!s2mm_axis_aresetn)
		begin
			state    <= cmd_idle;
			bank_ptr <= 1'b0;
			bank_ack <= 2'b00;
		end
		else
		begin
			case (state)
				cmd_idle:
					if (s_cmd_valid)
						state <= cmd_wait_bank;
				cmd_wait_bank:
					if (req_hit)
						state <= cmd_post;
				cmd_post:
					if (m_cmd_ready)
					begin
						bank_ack[bank_ptr] <= 1'b1; // command is out so the bank is released
						state <= cmd_wait_release;
					end
				cmd_wait_release:
					if (req_gone)
					begin
						bank_ack[bank_ptr] <= 1'b0;
						bank_ptr <= ~bank_ptr;
						state    <= last_chunk ? cmd_idle : cmd_wait_bank;
					end
				default:
					state <= cmd_idle;
			endcase
		end
	end

	// command payload
	always_ff @(posedge s2mm_axis_aclk)
	begin
		if (s_cmd_valid && s_cmd_ready)
		begin
			m_cmd_addr  <= s_cmd_addr;
			m_cmd_fixed <= s_cmd_fixed;
		end
		else if (req_gone && !m_cmd_fixed)
			m_cmd_addr <= m_cmd_addr + dma_addr_t'(m_cmd_btt); // next chunk follows on

		if (req_hit)
		begin
			m_cmd_btt  <= btt_t'(sel_bytes);
			last_chunk <= bank_last[bank_ptr];
		end
	end

	// ack only answers a pending request from the buffer
	a_ack_after_req: assert property (
		@(posedge s2mm_axis_aclk) disable iff (!s2mm_axis_aresetn)
		(bank_ack & ~$past(bank_ack) & ~bank_req) == 2'b00
	) else $error("bank_ack rose without bank_req");

endmodule

`default_nettype wire

// File: wdata_stat/wdata_pingpong_buf.sv
`timescale 1ns/1ps
`default_nettype none

module wdata_pingpong_buf (
	input  wire                        s2mm_axis_aclk,
	input  wire                        s2mm_axis_aresetn,

	// incoming beats
	input  wire s2mm_pkg::data_t       s_s2mm_data,
	input  wire s2mm_pkg::keep_t       s_s2mm_keep,
	input  wire                        s_s2mm_last,
	input  wire                        s_s2mm_valid,
	output logic                       s_s2mm_ready,

	// replayed beats
	output s2mm_pkg::data_t            m_s2mm_data,
	output s2mm_pkg::keep_t            m_s2mm_keep,
	output logic                       m_s2mm_last,
	output logic                       m_s2mm_valid,
	input  wire                        m_s2mm_ready,

	// bank reports to the command generator
	output logic [1:0]                 bank_req,
	output s2mm_pkg::byte_cnt_t        bank_bytes_0,
	output s2mm_pkg::byte_cnt_t        bank_bytes_1,
	output logic [1:0]                 bank_last,
	input  wire [1:0]                  bank_ack
);
	import s2mm_pkg::*;

	// bit 0 selects the bank and bit 1 is the wrap bit
	logic [1:0] wptr;
	logic [1:0] rptr;

	buf_addr_t waddr;
	buf_addr_t raddr;
	buf_addr_t last_addr [2]; // address of the closing beat per bank
	byte_cnt_t bytes_q [2];
	byte_cnt_t beat_bytes;

	logic buf_full;
	logic wr_fire;
	logic wr_close;
	logic [1:0] wen_b;

	logic rd_valid;
	logic rd_ready;
	logic rd_fire;
	logic rd_last;
	logic [1:0] ren_b;

	logic rsel;      // bank behind the output beat
	logic out_valid;
	logic out_last;

	logic [data_w+keep_w-1:0] ram_din;
	logic [data_w+keep_w-1:0] ram_dout [2];

	// both banks written and not yet replayed
	assign buf_full = (wptr[1] != rptr[1]) && (wptr[0] == rptr[0]);

	// next bank must be replayed and released by the command side
	assign s_s2mm_ready = !buf_full && !bank_req[wptr[0]] && !bank_ack[wptr[0]];

	assign wr_fire    = s_s2mm_valid && s_s2mm_ready;
	assign wr_close   = wr_fire && ((waddr == buf_addr_t'(buf_depth - 1)) || s_s2mm_last);
	assign wen_b      = {2{wr_fire}} & {wptr[0], ~wptr[0]};
	assign beat_bytes = byte_cnt_t'($countones(s_s2mm_keep));
	assign ram_din    = {s_s2mm_data, s_s2mm_keep};

	assign bank_bytes_0 = bytes_q[0];
	assign bank_bytes_1 = bytes_q[1];

	// write pointer and beat address
	always_ff @(posedge s2mm_axis_aclk or negedge s2mm_axis_aresetn)
	begin
		if (!s2mm_axis_aresetn)
		begin
			wptr  <= 2'b00;
			waddr <= '0;
		end
		else if (wr_fire)
		begin
			waddr <= wr_close ? '0 : waddr + 1'b1;
			if (wr_close)
				wptr <= wptr + 2'd1;
		end
	end

	// chunk end markers per bank
	always_ff @(posedge s2mm_axis_aclk)
	begin
		if (wr_close)
		begin
			last_addr[wptr[0]] <= waddr;
			bank_last[wptr[0]] <= s_s2mm_last;
		end
	end

	// byte counts and the buffer side of the req/ack
	always_ff @(posedge s2mm_axis_aclk or negedge s2mm_axis_aresetn)
	begin
		if (!s2mm_axis_aresetn)
		begin
			bank_req   <= 2'b00;
			bytes_q[0] <= '0;
			bytes_q[1] <= '0;
		end
		else
		begin
			for (int b = 0; b < 2; b++)
			begin
				if (bank_req[b] && bank_ack[b])
				begin
					bank_req[b] <= 1'b0; // command taken so the bank is released
					bytes_q[b]  <= '0;
				end
				else if (wen_b[b])
				begin
					bytes_q[b] <= bytes_q[b] + beat_bytes;
					if (wr_close)
						bank_req[b] <= 1'b1;
				end
			end
		end
	end

	// read side
	assign rd_valid = wptr != rptr;
	assign rd_ready = !out_valid || m_s2mm_ready; // stall RAM read under back-pressure
	assign rd_fire  = rd_valid && rd_ready;
	assign rd_last  = raddr == last_addr[rptr[0]];
	assign ren_b    = {2{rd_fire}} & {rptr[0], ~rptr[0]};

	always_ff @(posedge s2mm_axis_aclk or negedge s2mm_axis_aresetn)
	begin
		if (!s2mm_axis_aresetn)
		begin
			rptr      <= 2'b00;
			raddr     <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			if (rd_fire)
			begin
				raddr <= rd_last ? '0 : raddr + 1'b1;
				if (rd_last)
					rptr <= rptr + 2'd1;
			end
			if (rd_ready)
				out_valid <= rd_valid;
		end
	end

	always_ff @(posedge s2mm_axis_aclk)
	begin
		if (rd_fire)
		begin
			rsel     <= rptr[0];
			out_last <= rd_last;
		end
	end

	// the ram data register is the output stage and holds while not read
	assign {m_s2mm_data, m_s2mm_keep} = ram_dout[rsel];
	assign m_s2mm_last  = out_last;
	assign m_s2mm_valid = out_valid;

	for (genvar b = 0; b < 2; b++)
	begin : g_bank
		sp_ram i_ram (
			.s2mm_axis_aclk (s2mm_axis_aclk),
			.en             (wen_b[b] | ren_b[b]),
			.wen            (wen_b[b]),
			.addr           (wen_b[b] ? waddr : raddr),
			.din            (ram_din),
			.dout           (ram_dout[b])
		);
	end

	// a bank still owned by the command side is never overwritten
	a_no_write_busy: assert property (
		@(posedge s2mm_axis_aclk) disable iff (!s2mm_axis_aresetn)
		(wen_b & (bank_req | bank_ack)) == 2'b00
	) else $error("write into a bank in handshake");

	// held beat survives later writes into its bank
	a_out_stable: assert property (
		@(posedge s2mm_axis_aclk) disable iff (!s2mm_axis_aresetn)
		m_s2mm_valid && !m_s2mm_ready |=>
			m_s2mm_valid && $stable({m_s2mm_data, m_s2mm_keep, m_s2mm_last})
	) else $error("m_s2mm payload changed under back-pressure");

endmodule

`default_nettype wire
